// ==== sources.f ====
+incdir+tb
source/CommandPkg.sv
source/PixelPkg.sv
source/RegisterBank.sv
source/Rasterizer.sv
source/ColorBuffer.sv
source/CommandParser.sv
source/RenderCore.sv
tb/RenderCoreTb.sv

// ==== tb/RenderCoreTasks.svh ====
////////////////////////////////////////////////////////////
// Render core testbench tasks
// Command senders, reference image updates and per-test
// bookkeeping
////////////////////////////////////////////////////////////

`ifndef RenderCoreTasksSvh
`define RenderCoreTasksSvh

localparam int WordTimeout = 50;
localparam int OpTimeout   = 2000;

task automatic beginTest(input string name);
    testName      = name;
    testErrorBase = errorCount;
endtask

task automatic endTest();
    testsRun++;
    if (errorCount != testErrorBase)
    begin
        testsFailed++;
        $display("%s: FAIL", testName);
    end
    else
    begin
        $display("%s: PASS", testName);
    end
endtask

task automatic reportMismatch(input string what, input int expected, input int actual);
    errorCount++;
    $display("CHECK FAILED %s, %s: expected %0h actual %0h", testName, what, expected, actual);
endtask

task automatic reportError(input string msg);
    errorCount++;
    $display("%s: %s", testName, msg);
endtask

task automatic idleCycles(input int count);
    repeat (count) @(posedge aclk);
    #(Skew);
endtask

task automatic waitReady(input int limit, input string what);
    int cycles;
    cycles = 0;
    while (!cmdReady && cycles < limit)
    begin
        @(posedge aclk);
        #(Skew);
        cycles++;
    end
    if (!cmdReady)
    begin
        $display("Timeout waiting for cmdReady after %s in %s", what, testName);
        $display("test failed");
        $finish;
    end
endtask

task automatic sendWord(input cmdWordT word, input logic last);
    cmdValid = 1'b1;
    cmdData  = word;
    cmdLast  = last;
    waitReady(WordTimeout, "command word");
    @(posedge aclk);
    #(Skew);
    cmdValid = 1'b0;
endtask

task automatic sendConfig(input rgb565T clear, input cmdWordT scStart,
                          input cmdWordT scEnd, input logic scEnable);
    sendWord({opConfig, 28'h0}, 1'b0);
    sendWord({16'h0, clear}, 1'b0);
    sendWord(scStart, 1'b0);
    sendWord(scEnd, 1'b0);
    sendWord({31'h0, scEnable}, 1'b1);
    refClear    = clear;
    refScStart  = scStart;
    refScEnd    = scEnd;
    refScEnable = scEnable;
endtask

function automatic logic insideScissor(input int x, input int y);
    return !refScEnable
        || (x >= refScStart[15:0] && x <= refScEnd[15:0]
            && y >= refScStart[31:16] && y <= refScEnd[31:16]);
endfunction

task automatic sendFramebuffer(input logic memset, input logic commit);
    if (memset)
    begin
        for (int i = 0; i < PixelCount; i++)
            refImage[i] = refClear;
    end
    sendWord({opFramebuffer, 26'h0, memset, commit}, 1'b1);
    waitReady(OpTimeout, "buffer operation");
    if (commit)
    begin
        pixelCount : assert (streamIndex == PixelCount)
            else reportMismatch("pixel count", PixelCount, streamIndex);
    end
endtask
`endif

// ==== tb/RenderCoreTb.sv ====
////////////////////////////////////////////////////////////
// Render core testbench
// Sends commands, keeps a reference framebuffer and checks
// the committed stream with assertions
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module RenderCoreTb import CommandPkg::*, PixelPkg::*; ();

    localparam int XBits      = 3;
    localparam int YBits      = 3;
    localparam int Width      = 2 ** XBits;
    localparam int Height     = 2 ** YBits;
    localparam int PixelCount = Width * Height;
    localparam int Period     = 100;
    localparam int Skew       = 10;

    logic    aclk;
    logic    rst;
    logic    cmdValid;
    logic    cmdReady;
    logic    cmdLast;
    cmdWordT cmdData;
    logic    fbValid;
    logic    fbReady;
    logic    fbLast;
    rgb565T  fbData;

    // Reference framebuffer and config copy
    rgb565T  refImage [PixelCount];
    rgb565T  refClear;
    cmdWordT refScStart;
    cmdWordT refScEnd;
    logic    refScEnable;

    string testName;
    int    errorCount;
    int    testErrorBase;
    int    testsRun;
    int    testsFailed;
    int    streamIndex;
    logic  randomStall;

    `include "RenderCoreTasks.svh"

    RenderCore #(.XBits(XBits), .YBits(YBits)) dut (
        .aclk(aclk),
        .rst(rst),
        .cmdValid(cmdValid),
        .cmdReady(cmdReady),
        .cmdLast(cmdLast),
        .cmdData(cmdData),
        .fbValid(fbValid),
        .fbReady(fbReady),
        .fbLast(fbLast),
        .fbData(fbData)
    );

    initial
    begin
        aclk = 1'b0;
        forever #(Period / 2) aclk = ~aclk;
    end

    // Sink that stalls at random when asked
    initial
    begin
        void'($urandom(71));
        fbReady = 1'b1;
        forever
        begin
            @(posedge aclk);
            #(Skew);
            fbReady = randomStall ? (($urandom % 3) != 0) : 1'b1;
        end
    end

    // Position within the current commit
    always @(posedge aclk)
    begin
        if (rst || (cmdValid && cmdReady))
            streamIndex <= 0;
        else if (fbValid && fbReady)
            streamIndex <= streamIndex + 1;
    end

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////
    idleAfterReset : assert property (@(posedge aclk)
        $fell(rst) |-> (cmdReady && !fbValid))
        else reportError("DUT is not idle after reset");

    pixelMatches : assert property (@(posedge aclk) disable iff (rst)
        (fbValid && fbReady) |-> (streamIndex < PixelCount && fbData == refImage[streamIndex]))
        else reportMismatch($sformatf("pixel %0d", $sampled(streamIndex)),
                            refImage[$sampled(streamIndex) % PixelCount], $sampled(fbData));

    lastOnFinalPixel : assert property (@(posedge aclk) disable iff (rst)
        (fbValid && fbReady) |-> (fbLast == (streamIndex == PixelCount - 1)))
        else reportMismatch("fbLast", $sampled(streamIndex) == PixelCount - 1,
                            $sampled(fbLast));

    stallHolds : assert property (@(posedge aclk) disable iff (rst)
        (fbValid && !fbReady) |=> (fbValid && $stable(fbData)))
        else reportError("stream pixel changed or vanished while fbReady was low");

    ////////////////////////////////////////////////////////////
    // Triangle y >= 1, 2x >= y, x + y <= 10 over the full box
    ////////////////////////////////////////////////////////////
    task automatic drawTriangle(input rgb565T color);
        cmdWordT words [TriangleRegCount];
        edgeValT wRow [3];
        edgeValT wCur [3];
        int      x0;
        int      y0;
        int      x1;
        int      y1;
        words = '{{16'd0, 16'd0}, {16'd7, 16'd7},
                  -32'sd1, 32'sd0, 32'sd10,
                  32'sd0, 32'sd2, -32'sd1,
                  32'sd1, -32'sd1, -32'sd1,
                  {16'h0, color}};
        sendWord({opTriangle, 28'h0}, 1'b0);
        for (int i = 0; i < TriangleRegCount; i++)
            sendWord(words[i], i == TriangleRegCount - 1);
        waitReady(OpTimeout, "rasterizer");

        // Box corners with Y in the high half
        x0 = words[TriBbStart][15:0];
        y0 = words[TriBbStart][31:16];
        x1 = words[TriBbEnd][15:0];
        y1 = words[TriBbEnd][31:16];
        for (int k = 0; k < 3; k++)
            wRow[k] = words[TriW0 + k];

        // Only box positions inside the framebuffer are visited
        for (int y = y0; y <= y1 && y < Height; y++)
        begin
            wCur = wRow;
            for (int x = x0; x <= x1 && x < Width; x++)
            begin
                if (wCur[0] >= 0 && wCur[1] >= 0 && wCur[2] >= 0 && insideScissor(x, y))
                    refImage[y * Width + x] = color;
                for (int k = 0; k < 3; k++)
                    wCur[k] = wCur[k] + words[TriW0IncX + k];
            end
            for (int k = 0; k < 3; k++)
                wRow[k] = wRow[k] + words[TriW0IncY + k];
        end
    endtask

    initial
    begin
        rst         = 1'b1;
        cmdValid    = 1'b0;
        cmdLast     = 1'b0;
        cmdData     = '0;
        randomStall = 1'b0;
        errorCount  = 0;
        testsRun    = 0;
        testsFailed = 0;

        beginTest("reset");
        repeat (5) @(posedge aclk);
        #(Skew);
        rst = 1'b0;
        idleCycles(2);
        endTest();

        beginTest("clear and commit");
        sendConfig(16'h07E0, 32'h0, 32'h0, 1'b0);
        sendFramebuffer(1'b1, 1'b1);
        endTest();

        beginTest("triangle render");
        drawTriangle(16'hF800);
        sendFramebuffer(1'b0, 1'b1);
        endTest();

        // Y in the high half, X in the low half
        beginTest("scissor");
        sendConfig(16'h001F, {16'd2, 16'd2}, {16'd4, 16'd5}, 1'b1);
        sendFramebuffer(1'b1, 1'b0);
        drawTriangle(16'hFFE0);
        sendFramebuffer(1'b0, 1'b1);
        endTest();

        beginTest("back-pressure");
        randomStall = 1'b1;
        sendFramebuffer(1'b0, 1'b1);
        randomStall = 1'b0;
        endTest();

        $display("%0d tests, %0d failing, %0d check errors", testsRun, testsFailed, errorCount);
        if (testsFailed == 0 && errorCount == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

// ==== source/RenderCore.sv ====
////////////////////////////////////////////////////////////
// Render core top level
// Command parser, register banks, rasterizer and color buffer
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module RenderCore import CommandPkg::*, PixelPkg::*; #(
    parameter int XBits = 3,
    parameter int YBits = 3
) (
    input  logic    aclk,
    input  logic    rst,

    // Command stream
    input  logic    cmdValid,
    output logic    cmdReady,
    input  logic    cmdLast,
    input  cmdWordT cmdData,

    // Framebuffer stream
    output logic    fbValid,
    input  logic    fbReady,
    output logic    fbLast,
    output rgb565T  fbData
);

    cmdWordT wordData;
    logic    wordLast;
    logic    configLoad;
    logic    triangleLoad;
    logic    startRendering;
    logic    rasterizerRunning;
    logic    bufferApply;
    logic    bufferApplied;
    logic    cmdMemset;
    logic    cmdCommit;

    logic [ConfigRegCount*WordBits-1:0]   configRegs;
    logic [TriangleRegCount*WordBits-1:0] triangleRegs;

    logic      pixelValid;
    screenPosT pixelX;
    screenPosT pixelY;
    rgb565T    pixelColor;

    CommandParser commandParser (
        .aclk(aclk),
        .rst(rst),
        .cmdValid(cmdValid),
        .cmdReady(cmdReady),
        .cmdLast(cmdLast),
        .cmdData(cmdData),
        .rasterizerRunning(rasterizerRunning),
        .bufferApplied(bufferApplied),
        .wordData(wordData),
        .wordLast(wordLast),
        .configLoad(configLoad),
        .triangleLoad(triangleLoad),
        .startRendering(startRendering),
        .bufferApply(bufferApply),
        .cmdMemset(cmdMemset),
        .cmdCommit(cmdCommit)
    );

    RegisterBank #(.BankSize(ConfigRegCount)) configBank (
        .aclk(aclk),
        .rst(rst),
        .load(configLoad),
        .wordData(wordData),
        .wordLast(wordLast),
        .registers(configRegs)
    );

    RegisterBank #(.BankSize(TriangleRegCount)) triangleBank (
        .aclk(aclk),
        .rst(rst),
        .load(triangleLoad),
        .wordData(wordData),
        .wordLast(wordLast),
        .registers(triangleRegs)
    );

    Rasterizer #(.XBits(XBits), .YBits(YBits)) rasterizer (
        .aclk(aclk),
        .rst(rst),
        .startRendering(startRendering),
        .bbStart(triangleRegs[TriBbStart*WordBits +: WordBits]),
        .bbEnd(triangleRegs[TriBbEnd*WordBits +: WordBits]),
        .w0(triangleRegs[TriW0*WordBits +: WordBits]),
        .w1(triangleRegs[TriW1*WordBits +: WordBits]),
        .w2(triangleRegs[TriW2*WordBits +: WordBits]),
        .w0IncX(triangleRegs[TriW0IncX*WordBits +: WordBits]),
        .w1IncX(triangleRegs[TriW1IncX*WordBits +: WordBits]),
        .w2IncX(triangleRegs[TriW2IncX*WordBits +: WordBits]),
        .w0IncY(triangleRegs[TriW0IncY*WordBits +: WordBits]),
        .w1IncY(triangleRegs[TriW1IncY*WordBits +: WordBits]),
        .w2IncY(triangleRegs[TriW2IncY*WordBits +: WordBits]),
        .triColor(triangleRegs[TriColor*WordBits +: $bits(rgb565T)]),
        .rasterizerRunning(rasterizerRunning),
        .pixelValid(pixelValid),
        .pixelX(pixelX),
        .pixelY(pixelY),
        .pixelColor(pixelColor)
    );

    ColorBuffer #(.XBits(XBits), .YBits(YBits)) colorBuffer (
        .aclk(aclk),
        .rst(rst),
        .pixelValid(pixelValid),
        .pixelX(pixelX),
        .pixelY(pixelY),
        .pixelColor(pixelColor),
        .clearColor(configRegs[ConfClearColor*WordBits +: $bits(rgb565T)]),
        .scissorStart(configRegs[ConfScissorStart*WordBits +: WordBits]),
        .scissorEnd(configRegs[ConfScissorEnd*WordBits +: WordBits]),
        .scissorEnable(configRegs[ConfFeatureEnable*WordBits + FeatureScissorBit]),
        .bufferApply(bufferApply),
        .cmdMemset(cmdMemset),
        .cmdCommit(cmdCommit),
        .bufferApplied(bufferApplied),
        .fbValid(fbValid),
        .fbReady(fbReady),
        .fbLast(fbLast),
        .fbData(fbData)
    );

endmodule

// ==== source/CommandParser.sv ====
////////////////////////////////////////////////////////////
// Command parser
// Decodes headers, routes payload words to the banks and
// sequences rendering and color buffer operations
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module CommandParser import CommandPkg::*; (
    input  logic    aclk,
    input  logic    rst,

    input  logic    cmdValid,
    output logic    cmdReady,
    input  logic    cmdLast,
    input  cmdWordT cmdData,

    input  logic    rasterizerRunning,
    input  logic    bufferApplied,

    output cmdWordT wordData,
    output logic    wordLast,
    output logic    configLoad,
    output logic    triangleLoad,
    output logic    startRendering,
    output logic    bufferApply,
    output logic    cmdMemset,
    output logic    cmdCommit
);

    typedef enum logic [2:0] {
        idle,
        configPayload,
        trianglePayload,
        startRaster,
        waitRaster,
        applyBuffer,
        waitBuffer
    } stateT;

    stateT  state;
    opcodeT opcode;
    logic   headerAccepted;

    assign opcode = opcodeT'(cmdData[WordBits-1 -: 4]);
    assign headerAccepted = (state == idle) && cmdValid;

    // Stream only accepted while not busy
    assign cmdReady = (state == idle)
                   || (state == configPayload)
                   || (state == trianglePayload);

    assign wordData     = cmdData;
    assign wordLast     = cmdLast;
    assign configLoad   = (state == configPayload) && cmdValid;
    assign triangleLoad = (state == trianglePayload) && cmdValid;

    assign startRendering = (state == startRaster);
    assign bufferApply    = (state == applyBuffer);

    ////////////////////////////////////////////////////////////
    // Sequencer
    ////////////////////////////////////////////////////////////
    always_ff @(posedge aclk)
    begin
        if (rst)
        begin
            state <= idle;
        end
        else
        begin
            case (state)
                idle:
                begin
                    if (cmdValid)
                    begin
                        case (opcode)
                            opConfig:      state <= configPayload;
                            opTriangle:    state <= trianglePayload;
                            opFramebuffer: state <= applyBuffer;
                            default:       state <= idle;
                        endcase
                    end
                end
                configPayload:
                begin
                    if (cmdValid && cmdLast)
                    begin
                        state <= idle;
                    end
                end
                trianglePayload:
                begin
                    if (cmdValid && cmdLast)
                    begin
                        state <= startRaster;
                    end
                end
                startRaster:
                begin
                    state <= waitRaster;
                end
                waitRaster:
                begin
                    // Running is already high on entry
                    if (!rasterizerRunning)
                    begin
                        state <= idle;
                    end
                end
                applyBuffer:
                begin
                    state <= waitBuffer;
                end
                waitBuffer:
                begin
                    if (bufferApplied)
                    begin
                        state <= idle;
                    end
                end
                default:
                begin
                    state <= idle;
                end
            endcase
        end
    end

    // Framebuffer flags held for the whole operation
    always_ff @(posedge aclk)
    begin
        if (headerAccepted && (opcode == opFramebuffer))
        begin
            cmdMemset <= cmdData[MemsetBit];
            cmdCommit <= cmdData[CommitBit];
        end
    end

    startWhileIdle : assert property (@(posedge aclk) disable iff (rst)
        startRendering |-> !rasterizerRunning);

endmodule

// ==== source/ColorBuffer.sv ====
////////////////////////////////////////////////////////////
// Color buffer
// RGB565 pixel memory with scissor-tested writes, memset to
// the clear color and stream-out of the whole buffer
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module ColorBuffer import CommandPkg::*, PixelPkg::*; #(
    parameter int XBits = 3,
    parameter int YBits = 3
) (
    input  logic      aclk,
    input  logic      rst,

    input  logic      pixelValid,
    input  screenPosT pixelX,
    input  screenPosT pixelY,
    input  rgb565T    pixelColor,

    input  rgb565T    clearColor,
    input  cmdWordT   scissorStart,
    input  cmdWordT   scissorEnd,
    input  logic      scissorEnable,

    input  logic      bufferApply,
    input  logic      cmdMemset,
    input  logic      cmdCommit,
    output logic      bufferApplied,

    output logic      fbValid,
    input  logic      fbReady,
    output logic      fbLast,
    output rgb565T    fbData
);

    localparam int IndexBits  = XBits + YBits;
    localparam int PixelCount = 2 ** IndexBits;

    typedef logic [IndexBits-1:0] pixelIndexT;

    typedef enum logic [1:0] {
        idle,
        memset,
        stream,
        done
    } stateT;

    stateT      state;
    rgb565T     mem [PixelCount];
    pixelIndexT opIndex;
    pixelIndexT writeIndex;
    logic       inScissor;
    logic       pixelWrite;
    logic       lastIndex;

    // Inclusive rectangle, X low half and Y high half
    assign inScissor = (pixelX >= scissorStart[15:0]) && (pixelX <= scissorEnd[15:0])
                    && (pixelY >= scissorStart[31:16]) && (pixelY <= scissorEnd[31:16]);

    assign pixelWrite = pixelValid && (!scissorEnable || inScissor);
    assign writeIndex = {pixelY[YBits-1:0], pixelX[XBits-1:0]};
    assign lastIndex  = (opIndex == '1);

    assign fbValid       = (state == stream);
    assign fbLast        = fbValid && lastIndex;
    assign fbData        = mem[opIndex];
    assign bufferApplied = (state == done);

    always_ff @(posedge aclk)
    begin
        if (state == memset)
        begin
            mem[opIndex] <= clearColor;
        end
        else if (pixelWrite)
        begin
            mem[writeIndex] <= pixelColor;
        end
    end

    ////////////////////////////////////////////////////////////
    // Memset then commit
    ////////////////////////////////////////////////////////////
    always_ff @(posedge aclk)
    begin
        if (rst)
        begin
            state   <= idle;
            opIndex <= '0;
        end
        else
        begin
            case (state)
                idle:
                begin
                    opIndex <= '0;
                    if (bufferApply)
                    begin
                        if (cmdMemset)
                            state <= memset;
                        else if (cmdCommit)
                            state <= stream;
                        else
                            state <= done;
                    end
                end
                memset:
                begin
                    opIndex <= opIndex + 1'b1;
                    if (lastIndex)
                    begin
                        state <= cmdCommit ? stream : done;
                    end
                end
                stream:
                begin
                    if (fbReady)
                    begin
                        opIndex <= opIndex + 1'b1;
                        if (lastIndex)
                        begin
                            state <= done;
                        end
                    end
                end
                default:
                begin
                    state <= idle;
                end
            endcase
        end
    end

    stallHoldsData : assert property (@(posedge aclk) disable iff (rst)
        (fbValid && !fbReady) |=> (fbValid && $stable(fbData)));

endmodule

// ==== source/Rasterizer.sv ====
////////////////////////////////////////////////////////////
// Rasterizer
// Walks the clipped bounding box, steps three edge functions
// and flags the covered positions
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module Rasterizer import CommandPkg::*, PixelPkg::*; #(
    parameter int XBits = 3,
    parameter int YBits = 3
) (
    input  logic      aclk,
    input  logic      rst,
    input  logic      startRendering,

    input  cmdWordT   bbStart,
    input  cmdWordT   bbEnd,
    input  edgeValT   w0,
    input  edgeValT   w1,
    input  edgeValT   w2,
    input  edgeValT   w0IncX,
    input  edgeValT   w1IncX,
    input  edgeValT   w2IncX,
    input  edgeValT   w0IncY,
    input  edgeValT   w1IncY,
    input  edgeValT   w2IncY,
    input  rgb565T    triColor,

    output logic      rasterizerRunning,
    output logic      pixelValid,
    output screenPosT pixelX,
    output screenPosT pixelY,
    output rgb565T    pixelColor
);

    localparam screenPosT XMax = screenPosT'(2 ** XBits - 1);
    localparam screenPosT YMax = screenPosT'(2 ** YBits - 1);

    edgeValT   incX [3];
    edgeValT   incY [3];
    edgeValT   wCur [3];
    edgeValT   wRow [3];
    screenPosT startX;
    screenPosT startY;
    screenPosT clipEndX;
    screenPosT clipEndY;
    screenPosT xStart;
    screenPosT xEnd;
    screenPosT yEnd;
    logic      boxEmpty;

    assign incX = '{w0IncX, w1IncX, w2IncX};
    assign incY = '{w0IncY, w1IncY, w2IncY};

    // Clip box end to the framebuffer
    assign startX   = bbStart[15:0];
    assign startY   = bbStart[31:16];
    assign clipEndX = (bbEnd[15:0] > XMax) ? XMax : bbEnd[15:0];
    assign clipEndY = (bbEnd[31:16] > YMax) ? YMax : bbEnd[31:16];
    assign boxEmpty = (startX > clipEndX) || (startY > clipEndY);

    assign pixelValid = rasterizerRunning
                     && (wCur[0] >= 0) && (wCur[1] >= 0) && (wCur[2] >= 0);

    always_ff @(posedge aclk)
    begin
        if (rst)
        begin
            rasterizerRunning <= 1'b0;
        end
        else if (startRendering)
        begin
            rasterizerRunning <= !boxEmpty;
        end
        else if (rasterizerRunning && (pixelX == xEnd) && (pixelY == yEnd))
        begin
            rasterizerRunning <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////
    // Box walk, X fastest
    ////////////////////////////////////////////////////////////
    always_ff @(posedge aclk)
    begin
        if (startRendering)
        begin
            pixelX     <= startX;
            pixelY     <= startY;
            xStart     <= startX;
            xEnd       <= clipEndX;
            yEnd       <= clipEndY;
            pixelColor <= triColor;
            wCur       <= '{w0, w1, w2};
            wRow       <= '{w0, w1, w2};
        end
        else if (rasterizerRunning)
        begin
            if (pixelX == xEnd)
            begin
                pixelX <= xStart;
                pixelY <= pixelY + 1'b1;
                for (int i = 0; i < 3; i++)
                begin
                    wRow[i] <= wRow[i] + incY[i];
                    wCur[i] <= wRow[i] + incY[i];
                end
            end
            else
            begin
                pixelX <= pixelX + 1'b1;
                for (int i = 0; i < 3; i++)
                begin
                    wCur[i] <= wCur[i] + incX[i];
                end
            end
        end
    end

endmodule

// ==== source/RegisterBank.sv ====
////////////////////////////////////////////////////////////
// Register bank
// Stores consecutive payload words into a flat register array
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module RegisterBank import CommandPkg::*; #(
    parameter int BankSize = 4
) (
    input  logic                         aclk,
    input  logic                         rst,
    input  logic                         load,
    input  cmdWordT                      wordData,
    input  logic                         wordLast,
    output logic [BankSize*WordBits-1:0] registers
);

    logic [$clog2(BankSize+1)-1:0] count;

    always_ff @(posedge aclk)
    begin
        if (rst)
        begin
            count <= '0;
        end
        else if (load)
        begin
            count <= wordLast ? '0 : count + 1'b1;
        end
    end

    always_ff @(posedge aclk)
    begin
        if (load)
        begin
            registers[count*WordBits +: WordBits] <= wordData;
        end
    end

    // Payload length must fit the bank
    loadInRange : assert property (@(posedge aclk) disable iff (rst)
        load |-> (count < BankSize));

endmodule

// ==== source/PixelPkg.sv ====
////////////////////////////////////////////////////////////
// Pixel definitions
// Screen coordinates, edge function values and colors
////////////////////////////////////////////////////////////

package PixelPkg;

    // Unsigned screen coordinate, X or Y
    typedef logic [15:0] screenPosT;

    // Edge function value, inside when zero or greater
    typedef logic signed [31:0] edgeValT;

    // R in 15:11, G in 10:5, B in 4:0
    typedef logic [15:0] rgb565T;

endpackage

// ==== source/CommandPkg.sv ====
////////////////////////////////////////////////////////////
// Command stream definitions
// Header word layout, opcodes and the register indices of
// the config and triangle banks
////////////////////////////////////////////////////////////

package CommandPkg;

    localparam int WordBits = 32;

    typedef logic [WordBits-1:0] cmdWordT;

    // Opcode sits in the top nibble of a header
    typedef enum logic [3:0] {
        opNop         = 4'h0,
        opConfig      = 4'h1,
        opTriangle    = 4'h2,
        opFramebuffer = 4'h3
    } opcodeT;

    // opFramebuffer header flags
    localparam int CommitBit = 0;
    localparam int MemsetBit = 1;

    ////////////////////////////////////////////////////////////
    // Config bank
    ////////////////////////////////////////////////////////////
    localparam int ConfigRegCount    = 4;
    localparam int ConfClearColor    = 0;
    localparam int ConfScissorStart  = 1;
    localparam int ConfScissorEnd    = 2;
    localparam int ConfFeatureEnable = 3;

    localparam int FeatureScissorBit = 0;

    ////////////////////////////////////////////////////////////
    // Triangle bank
    ////////////////////////////////////////////////////////////
    localparam int TriangleRegCount = 12;
    localparam int TriBbStart       = 0;
    localparam int TriBbEnd         = 1;
    localparam int TriW0            = 2;
    localparam int TriW1            = 3;
    localparam int TriW2            = 4;
    localparam int TriW0IncX        = 5;
    localparam int TriW1IncX        = 6;
    localparam int TriW2IncX        = 7;
    localparam int TriW0IncY        = 8;
    localparam int TriW1IncY        = 9;
    localparam int TriW2IncY        = 10;
    localparam int TriColor         = 11;

endpackage
